// File: logic/spi_bridge_pkg.sv
/*
 * shared definitions for the avalon to spi bridge
 *   data and address widths, register map
 *   control and status bit positions, soft reset code
 *   host wait timing, block-to-block structs
 *   read select and sequencer state enums
 */
package spi_bridge_pkg;

	// bus word and register address
	typedef logic [31:0] word_t;
	typedef logic [7:0] addr_t;

	// register map
	localparam addr_t ADDR_CONTROL = 8'h00;
	localparam addr_t ADDR_STATUS = 8'h01;
	localparam addr_t ADDR_DATA_WRITE = 8'h02;
	localparam addr_t ADDR_DATA_READ = 8'h03;
	localparam addr_t ADDR_RESET = 8'h04;

	// control register bits, all self-clearing
	localparam int CTRL_WR_BIT = 0;
	localparam int CTRL_RD_BIT = 1;
	localparam int CTRL_IRQ_RESET_BIT = 2;

	// status register bits
	localparam int STAT_BUSY_WRITE_BIT = 0;
	localparam int STAT_BUSY_READ_BIT = 1;
	localparam int STAT_READ_READY_BIT = 2;

	// only this word at ADDR_RESET restarts the bridge
	localparam word_t SOFT_RESET_CODE = 32'hA5A5_A5A5;

	// wait_request high this many cycles per access
	localparam int WAIT_CYCLES = 2;
	localparam int WAIT_CNT_W = $clog2(WAIT_CYCLES + 1);
	typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

	typedef enum logic [1:0] {SEL_NONE, SEL_STATUS, SEL_DATA_READ} read_sel_t;

	// one-cycle command pulses from the host side
	typedef struct packed {
		logic start_write;
		logic start_read;
		logic irq_clear;
		logic soft_reset;
	} host_cmd_t;

	// sequencer progress toward the readback side
	typedef struct packed {
		logic busy_write;
		logic busy_read;
		logic read_done;
		word_t read_word;
	} seq_status_t;

	typedef enum logic [2:0] {IDLE, WRITE_START, WRITE_WAIT, READ_START, READ_WAIT} seq_state_t;

endpackage

// File: logic/host_port.sv
/*
 * avalon-mm host side of the bridge
 *   fixed wait_request per access
 *   address decode at the accepting edge
 *   write-data register, control and soft reset pulses
 */
`timescale 1ns/1ps

module host_port (
	input logic clk,
	input logic reset_n,
	input logic chip_select,
	input logic read,
	input logic write,
	input spi_bridge_pkg::addr_t address,
	input spi_bridge_pkg::word_t write_data,
	output logic wait_request,
	output spi_bridge_pkg::host_cmd_t host_cmd,
	output spi_bridge_pkg::read_sel_t read_sel,
	output spi_bridge_pkg::word_t data_write
);

	//////////////////////////////////////////////////
	// access timing
	//////////////////////////////////////////////////

	logic access;
	logic accept;
	spi_bridge_pkg::wait_cnt_t wait_cnt;

	// an access is any strobe under chip_select
	assign access = chip_select & (read | write);

	// third cycle of the access, wait already counted out
	assign accept = access && (wait_cnt == spi_bridge_pkg::wait_cnt_t'(spi_bridge_pkg::WAIT_CYCLES));

	// low when idle, low in the accepting cycle
	assign wait_request = access & ~accept;

	// counts waited cycles of the current access
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wait_cnt <= '0;
		end
		else if (!access || accept)
		begin
			// restart for the next access
			wait_cnt <= '0;
		end
		else
		begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// write decode
	//////////////////////////////////////////////////

	// command pulses, one cycle after the accepting edge
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			host_cmd <= '0;
		end
		else
		begin
			// default low, so every bit self-clears
			host_cmd <= '0;
			if (accept && write)
			begin
				case (address)
					spi_bridge_pkg::ADDR_CONTROL:
					begin
						host_cmd.start_write <= write_data[spi_bridge_pkg::CTRL_WR_BIT];
						host_cmd.start_read <= write_data[spi_bridge_pkg::CTRL_RD_BIT];
						host_cmd.irq_clear <= write_data[spi_bridge_pkg::CTRL_IRQ_RESET_BIT];
					end
					spi_bridge_pkg::ADDR_RESET:
					begin
						// any other value is ignored
						host_cmd.soft_reset <= (write_data == spi_bridge_pkg::SOFT_RESET_CODE);
					end
					default:
					begin
						host_cmd <= '0;
					end
				endcase
			end
		end
	end

	// write-data register, feeds the spi engine directly
	always_ff @(posedge clk)
	begin
		if (host_cmd.soft_reset)
		begin
			data_write <= '0;
		end
		else if (accept && write && (address == spi_bridge_pkg::ADDR_DATA_WRITE))
		begin
			data_write <= write_data;
		end
	end

	//////////////////////////////////////////////////
	// read decode
	//////////////////////////////////////////////////

	// valid only in the accepting cycle
	always_comb
	begin
		read_sel = spi_bridge_pkg::SEL_NONE;
		if (accept && read && !write)
		begin
			case (address)
				spi_bridge_pkg::ADDR_STATUS:
					read_sel = spi_bridge_pkg::SEL_STATUS;
				spi_bridge_pkg::ADDR_DATA_READ:
					read_sel = spi_bridge_pkg::SEL_DATA_READ;
				default:
					read_sel = spi_bridge_pkg::SEL_NONE;
			endcase
		end
	end

endmodule

// File: logic/transfer_sequencer.sv
/*
 * spi transfer sequencing
 *   state machine over write and read transfers
 *   single-cycle go_transfer
 *   falling edge detect on data_pack_ready, read capture
 */
`timescale 1ns/1ps

module transfer_sequencer (
	input logic clk,
	input logic reset_n,
	input spi_bridge_pkg::host_cmd_t host_cmd,
	input spi_bridge_pkg::word_t data_write,
	input logic data_pack_ready,
	input spi_bridge_pkg::word_t data_read_from_spi,
	output logic go_transfer,
	output spi_bridge_pkg::word_t data_write_to_spi,
	output spi_bridge_pkg::seq_status_t seq_status
);

	spi_bridge_pkg::seq_state_t state;
	spi_bridge_pkg::seq_state_t state_next;

	logic pack_q;
	logic pack_fall;
	logic read_done;
	spi_bridge_pkg::word_t read_word;

	//////////////////////////////////////////////////
	// completion detect
	//////////////////////////////////////////////////

	// sampled high, then sampled low
	// pack_fall is high one cycle after the low sample
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			pack_q <= 1'b0;
			pack_fall <= 1'b0;
		end
		else
		begin
			pack_q <= data_pack_ready;
			pack_fall <= pack_q & ~data_pack_ready;
		end
	end

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			spi_bridge_pkg::IDLE:
			begin
				// write wins if both bits come together
				if (host_cmd.start_write)
					state_next = spi_bridge_pkg::WRITE_START;
				else if (host_cmd.start_read)
					state_next = spi_bridge_pkg::READ_START;
			end
			spi_bridge_pkg::WRITE_START:
				state_next = spi_bridge_pkg::WRITE_WAIT;
			spi_bridge_pkg::WRITE_WAIT:
			begin
				if (pack_fall)
					state_next = spi_bridge_pkg::IDLE;
			end
			spi_bridge_pkg::READ_START:
				state_next = spi_bridge_pkg::READ_WAIT;
			spi_bridge_pkg::READ_WAIT:
			begin
				if (pack_fall)
					state_next = spi_bridge_pkg::IDLE;
			end
			default:
				state_next = spi_bridge_pkg::IDLE;
		endcase

		// soft reset aborts any transfer
		if (host_cmd.soft_reset)
			state_next = spi_bridge_pkg::IDLE;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= spi_bridge_pkg::IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////
	// read completion and capture
	//////////////////////////////////////////////////

	// pulse together with the return to IDLE
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_done <= 1'b0;
		end
		else
		begin
			read_done <= (state == spi_bridge_pkg::READ_WAIT) & pack_fall & ~host_cmd.soft_reset;
		end
	end

	// engine holds its word stable after the falling edge
	always_ff @(posedge clk)
	begin
		if ((state == spi_bridge_pkg::READ_WAIT) && pack_fall)
		begin
			read_word <= data_read_from_spi;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	// one cycle, from either start state
	assign go_transfer = (state == spi_bridge_pkg::WRITE_START)
		|| (state == spi_bridge_pkg::READ_START);

	// the write-data register is already in place at go_transfer
	assign data_write_to_spi = data_write;

	// busy from go_transfer until back in IDLE
	assign seq_status.busy_write = (state == spi_bridge_pkg::WRITE_START)
		|| (state == spi_bridge_pkg::WRITE_WAIT);
	assign seq_status.busy_read = (state == spi_bridge_pkg::READ_START)
		|| (state == spi_bridge_pkg::READ_WAIT);
	assign seq_status.read_done = read_done;
	assign seq_status.read_word = read_word;

endmodule

// File: logic/status_readback.sv
/*
 * host readback path
 *   read-ready flag and irq
 *   last captured spi word
 *   status word and read-data mux
 */
`timescale 1ns/1ps

module status_readback (
	input logic clk,
	input logic reset_n,
	input spi_bridge_pkg::host_cmd_t host_cmd,
	input spi_bridge_pkg::read_sel_t read_sel,
	input spi_bridge_pkg::seq_status_t seq_status,
	output spi_bridge_pkg::word_t read_data,
	output logic irq
);

	logic read_ready;
	spi_bridge_pkg::word_t data_read;
	spi_bridge_pkg::word_t status_word;

	// set after read_done, cleared by irq_clear or soft reset
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_ready <= 1'b0;
		end
		else if (host_cmd.soft_reset)
		begin
			read_ready <= 1'b0;
		end
		else if (seq_status.read_done)
		begin
			read_ready <= 1'b1;
		end
		else if (host_cmd.irq_clear)
		begin
			read_ready <= 1'b0;
		end
	end

	// irq follows the read-ready flag
	assign irq = read_ready;

	// captured word, kept over irq_clear
	always_ff @(posedge clk)
	begin
		if (host_cmd.soft_reset)
			data_read <= '0;
		else if (seq_status.read_done)
			data_read <= seq_status.read_word;
	end

	// status register image
	always_comb
	begin
		status_word = '0;
		status_word[spi_bridge_pkg::STAT_BUSY_WRITE_BIT] = seq_status.busy_write;
		status_word[spi_bridge_pkg::STAT_BUSY_READ_BIT] = seq_status.busy_read;
		status_word[spi_bridge_pkg::STAT_READ_READY_BIT] = read_ready;
	end

	// zero for unmapped reads and outside the accepting cycle
	always_comb
	begin
		case (read_sel)
			spi_bridge_pkg::SEL_STATUS:
				read_data = status_word;
			spi_bridge_pkg::SEL_DATA_READ:
				read_data = data_read;
			default:
				read_data = '0;
		endcase
	end

endmodule

// File: logic/spi_bridge_top.sv
/*
 * avalon-mm to spi bridge top level
 *   host port, transfer sequencer, status readback
 */
`timescale 1ns/1ps

module spi_bridge_top (
	input logic clk,
	input logic reset_n,

	// avalon-mm slave
	input logic chip_select,
	input spi_bridge_pkg::addr_t address,
	input logic read,
	input logic write,
	input spi_bridge_pkg::word_t write_data,
	output spi_bridge_pkg::word_t read_data,
	output logic wait_request,
	output logic irq,

	// spi engine
	input logic data_pack_ready,
	input spi_bridge_pkg::word_t data_read_from_spi,
	output logic go_transfer,
	output spi_bridge_pkg::word_t data_write_to_spi
);

	spi_bridge_pkg::host_cmd_t host_cmd;
	spi_bridge_pkg::read_sel_t read_sel;
	spi_bridge_pkg::word_t data_write;
	spi_bridge_pkg::seq_status_t seq_status;

	// access timing and register decode
	host_port host_port_i (
		.clk (clk),
		.reset_n (reset_n),
		.chip_select (chip_select),
		.read (read),
		.write (write),
		.address (address),
		.write_data (write_data),
		.wait_request (wait_request),
		.host_cmd (host_cmd),
		.read_sel (read_sel),
		.data_write (data_write)
	);

	// spi transfers
	transfer_sequencer transfer_sequencer_i (
		.clk (clk),
		.reset_n (reset_n),
		.host_cmd (host_cmd),
		.data_write (data_write),
		.data_pack_ready (data_pack_ready),
		.data_read_from_spi (data_read_from_spi),
		.go_transfer (go_transfer),
		.data_write_to_spi (data_write_to_spi),
		.seq_status (seq_status)
	);

	// status, captured word, irq
	status_readback status_readback_i (
		.clk (clk),
		.reset_n (reset_n),
		.host_cmd (host_cmd),
		.read_sel (read_sel),
		.seq_status (seq_status),
		.read_data (read_data),
		.irq (irq)
	);

endmodule

// File: bench/spi_bridge_tb.sv
/*
 * directed testbench for the avalon-mm to spi bridge
 *   clock, reset, spi engine model, watchdog
 *   avalon read and write tasks with wait_request counting
 *   one task per test, result report
 */
`timescale 1ns/1ps

module spi_bridge_tb;

	logic clk;
	logic reset_n;
	logic chip_select;
	logic read;
	logic write;
	spi_bridge_pkg::addr_t address;
	spi_bridge_pkg::word_t write_data;
	spi_bridge_pkg::word_t read_data;
	logic wait_request;
	logic irq;
	logic data_pack_ready;
	spi_bridge_pkg::word_t data_read_from_spi;
	logic go_transfer;
	spi_bridge_pkg::word_t data_write_to_spi;

	// result counters
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// engine model bookkeeping
	integer seed = 32'h8ad3_4e5f;
	int go_count = 0;
	logic engine_busy = 1'b0;
	spi_bridge_pkg::word_t go_word = '0;
	spi_bridge_pkg::word_t spi_word = '0;
	spi_bridge_pkg::word_t last_read_word = '0;

	spi_bridge_top dut_i (
		.clk (clk),
		.reset_n (reset_n),
		.chip_select (chip_select),
		.address (address),
		.read (read),
		.write (write),
		.write_data (write_data),
		.read_data (read_data),
		.wait_request (wait_request),
		.irq (irq),
		.data_pack_ready (data_pack_ready),
		.data_read_from_spi (data_read_from_spi),
		.go_transfer (go_transfer),
		.data_write_to_spi (data_write_to_spi)
	);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// spi engine model
	//////////////////////////////////////////////////

	// busy for 3 to 10 cycles, then returns a random word
	initial
	begin
		int delay;
		data_pack_ready = 1'b0;
		data_read_from_spi = '0;
		forever
		begin
			@(negedge clk);
			if (reset_n && go_transfer)
			begin
				go_word = data_write_to_spi;
				engine_busy = 1'b1;
				data_pack_ready = 1'b1;
				delay = 3 + ({$random(seed)} % 8);
				repeat (delay) @(negedge clk);
				spi_word = $random(seed);
				// word stable before the falling edge of data_pack_ready
				data_read_from_spi = spi_word;
				data_pack_ready = 1'b0;
				engine_busy = 1'b0;
			end
		end
	end

	// every cycle with go_transfer high, busy engine or not
	always @(negedge clk)
	begin
		if (reset_n && go_transfer)
			go_count++;
	end

	// watchdog, 6 tests of at most 200 cycles each
	initial
	begin
		#(6 * 200 * 8);
		$display("run timed out after %0d ns", 6 * 200 * 8);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic compare(input string what, input spi_bridge_pkg::word_t got,
		input spi_bridge_pkg::word_t expected);
		if (got !== expected)
		begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	// one avalon access, held until the accepting edge
	task automatic host_access(input logic is_write, input spi_bridge_pkg::addr_t addr,
		input spi_bridge_pkg::word_t wdata, output spi_bridge_pkg::word_t rdata);
		int waits;
		waits = 0;
		@(negedge clk);
		chip_select = 1'b1;
		write = is_write;
		read = ~is_write;
		address = addr;
		write_data = wdata;
		#1;
		while (wait_request && (waits <= 8))
		begin
			waits++;
			@(negedge clk);
			#1;
		end
		compare("wait_request cycles", waits, spi_bridge_pkg::WAIT_CYCLES);
		// accepting cycle, read_data valid here
		rdata = read_data;
		@(negedge clk);
		chip_select = 1'b0;
		read = 1'b0;
		write = 1'b0;
	endtask

	task automatic bus_write(input spi_bridge_pkg::addr_t addr, input spi_bridge_pkg::word_t data);
		spi_bridge_pkg::word_t unused;
		host_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input spi_bridge_pkg::addr_t addr, output spi_bridge_pkg::word_t data);
		host_access(1'b0, addr, '0, data);
	endtask

	// status reads while the busy image holds, then idle expected
	task automatic poll_until_idle(input spi_bridge_pkg::word_t busy_status,
		input int max_reads);
		spi_bridge_pkg::word_t status;
		int reads;
		status = busy_status;
		reads = 0;
		while ((status == busy_status) && (reads < max_reads))
		begin
			bus_read(spi_bridge_pkg::ADDR_STATUS, status);
			reads++;
		end
		if (status == busy_status)
		begin
			$display("transfer still busy after %0d status reads", max_reads);
			errors++;
		end
		else
		begin
			compare("status at end of transfer", status, '0);
			// busy must outlast the engine
			if (engine_busy)
			begin
				$display("status went idle while the spi engine was still busy");
				errors++;
			end
		end
	endtask

	task automatic wait_for_irq(input int max_cycles);
		int cycles;
		cycles = 0;
		while (!irq && (cycles < max_cycles))
		begin
			@(negedge clk);
			cycles++;
		end
		if (!irq)
		begin
			$display("irq did not rise within %0d cycles", max_cycles);
			errors++;
		end
	endtask

	task automatic wait_engine_idle(input int max_cycles);
		int cycles;
		cycles = 0;
		while (engine_busy && (cycles < max_cycles))
		begin
			@(negedge clk);
			cycles++;
		end
		if (engine_busy)
		begin
			$display("spi engine model still busy after %0d cycles", max_cycles);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic check_reset_state();
		spi_bridge_pkg::word_t rdata;
		@(negedge clk);
		compare("wait_request after reset", 32'(wait_request), '0);
		compare("irq after reset", 32'(irq), '0);
		compare("go_transfer after reset", 32'(go_transfer), '0);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after reset", rdata, '0);
		// unmapped address reads zero
		bus_read(8'h07, rdata);
		compare("unmapped read", rdata, '0);
	endtask

	task automatic write_transfer();
		spi_bridge_pkg::word_t rdata;
		int go_before;
		go_before = go_count;
		bus_write(spi_bridge_pkg::ADDR_DATA_WRITE, 32'hC3A5_0F96);
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_WR_BIT);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status during write", rdata, 32'd1 << spi_bridge_pkg::STAT_BUSY_WRITE_BIT);
		poll_until_idle(32'd1 << spi_bridge_pkg::STAT_BUSY_WRITE_BIT, 20);
		wait_engine_idle(20);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after write", rdata, '0);
		compare("go_transfer pulses", go_count - go_before, 1);
		compare("data_write_to_spi", go_word, 32'hC3A5_0F96);
		compare("irq after write", 32'(irq), '0);
	endtask

	task automatic read_transfer();
		spi_bridge_pkg::word_t rdata;
		int go_before;
		go_before = go_count;
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_RD_BIT);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status during read", rdata, 32'd1 << spi_bridge_pkg::STAT_BUSY_READ_BIT);
		wait_for_irq(40);
		last_read_word = spi_word;
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after read", rdata, 32'd1 << spi_bridge_pkg::STAT_READ_READY_BIT);
		bus_read(spi_bridge_pkg::ADDR_DATA_READ, rdata);
		compare("read word", rdata, last_read_word);
		compare("go_transfer pulses", go_count - go_before, 1);
	endtask

	task automatic irq_clear();
		spi_bridge_pkg::word_t rdata;
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_IRQ_RESET_BIT);
		// flag drops one cycle after the pulse
		@(negedge clk);
		compare("irq after clear", 32'(irq), '0);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after clear", rdata, '0);
		bus_read(spi_bridge_pkg::ADDR_DATA_READ, rdata);
		compare("read word after clear", rdata, last_read_word);
	endtask

	task automatic busy_write_ignored();
		spi_bridge_pkg::word_t rdata;
		int go_before;
		go_before = go_count;
		bus_write(spi_bridge_pkg::ADDR_DATA_WRITE, 32'h0BAD_F00D);
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_WR_BIT);
		// lands while the first transfer is still running
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_WR_BIT);
		poll_until_idle(32'd1 << spi_bridge_pkg::STAT_BUSY_WRITE_BIT, 20);
		wait_engine_idle(20);
		repeat (10) @(negedge clk);
		compare("go_transfer pulses", go_count - go_before, 1);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after write", rdata, '0);
	endtask

	task automatic soft_reset();
		spi_bridge_pkg::word_t rdata;
		int go_before;
		// wrong code is ignored
		bus_write(spi_bridge_pkg::ADDR_RESET, 32'h5A5A_5A5A);
		bus_read(spi_bridge_pkg::ADDR_DATA_READ, rdata);
		compare("read word after wrong code", rdata, last_read_word);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after wrong code", rdata, '0);
		go_before = go_count;
		bus_write(spi_bridge_pkg::ADDR_CONTROL, 32'd1 << spi_bridge_pkg::CTRL_RD_BIT);
		bus_write(spi_bridge_pkg::ADDR_RESET, spi_bridge_pkg::SOFT_RESET_CODE);
		compare("go_transfer pulses", go_count - go_before, 1);
		bus_read(spi_bridge_pkg::ADDR_STATUS, rdata);
		compare("status after soft reset", rdata, '0);
		// aborted read must not raise irq on completion
		wait_engine_idle(20);
		repeat (4) @(negedge clk);
		compare("irq after soft reset", 32'(irq), '0);
		bus_read(spi_bridge_pkg::ADDR_DATA_READ, rdata);
		compare("read word after soft reset", rdata, '0);
	endtask

	//////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////

	initial
	begin
		int errors_before;
		reset_n = 1'b0;
		chip_select = 1'b0;
		read = 1'b0;
		write = 1'b0;
		address = '0;
		write_data = '0;
		repeat (5) @(negedge clk);
		reset_n = 1'b1;

		errors_before = errors;
		check_reset_state();
		finish_test("reset state", errors_before);
		errors_before = errors;
		write_transfer();
		finish_test("write transfer", errors_before);
		errors_before = errors;
		read_transfer();
		finish_test("read transfer", errors_before);
		errors_before = errors;
		irq_clear();
		finish_test("irq clear", errors_before);
		errors_before = errors;
		busy_write_ignored();
		finish_test("command while busy", errors_before);
		errors_before = errors;
		soft_reset();
		finish_test("soft reset", errors_before);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
logic/spi_bridge_pkg.sv
logic/host_port.sv
logic/transfer_sequencer.sv
logic/status_readback.sv
logic/spi_bridge_top.sv
bench/spi_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module spi_bridge_tb -o spi_bridge_sim \
	&& ./obj_dir/spi_bridge_sim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
